// ==== verilog/sram_test_pkg.sv ====
`default_nettype none

package sram_test_pkg;

  // data pattern currently written and checked
  typedef enum logic [2:0] {
    PAT_ZEROS = 3'd0,
    PAT_ONES  = 3'd1,
    PAT_55    = 3'd2,
    PAT_AA    = 3'd3,
    PAT_ADDR  = 3'd4
  } pattern_kind_e;

  // number of entries in pattern_kind_e
  localparam int PATTERN_COUNT = 5;

  // test sequencer states
  typedef enum logic [2:0] {
    ST_START,
    // one write request, then wait for ready
    ST_WRITE,
    ST_WRITE_WAIT,
    // one read request, then wait for ready
    ST_READ,
    ST_READ_WAIT,
    // all patterns clean
    ST_DONE,
    // mismatch seen, results frozen
    ST_HALT
  } tester_state_e;

endpackage

`default_nettype wire

// ==== verilog/sram_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sram_req_if #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
);

  // request side, valid with req
  logic                 req;
  logic                 write_enable;
  logic [ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0] write_data;

  // completion side
  logic                 ready;
  // held until the next read completes
  logic [DATA_BITS-1:0] read_data;

  modport tester (
    output req,
    output write_enable,
    output addr,
    output write_data,
    input  ready,
    input  read_data
  );

  modport controller (
    input  req,
    input  write_enable,
    input  addr,
    input  write_data,
    output ready,
    output read_data
  );

endinterface

`default_nettype wire

// ==== verilog/sram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_controller #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  sram_req_if.controller            bus,
  output logic      [ADDR_BITS-1:0] addr_bus,
  inout  wire       [DATA_BITS-1:0] data_bus,
  output logic                      we_n,
  output logic                      oe_n,
  output logic                      ce_n
);

  // one access walks idle -> setup -> strobe -> finish
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_SETUP,
    CTRL_STROBE,
    CTRL_FINISH
  } ctrl_state_e;

  ctrl_state_e          state;
  logic                 write_cycle;
  logic                 drive_data;
  logic [DATA_BITS-1:0] write_reg;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= CTRL_IDLE;
      write_cycle <= 1'b0;
      drive_data  <= 1'b0;
      ce_n        <= 1'b1;
      we_n        <= 1'b1;
      oe_n        <= 1'b1;
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (bus.req) begin
            state       <= CTRL_SETUP;
            write_cycle <= bus.write_enable;
            drive_data  <= bus.write_enable;
            ce_n        <= 1'b0;
          end
        end
        CTRL_SETUP: begin
          // address and data have had a full cycle to settle
          state <= CTRL_STROBE;
          we_n  <= !write_cycle;
          oe_n  <= write_cycle;
        end
        CTRL_STROBE: begin
          state <= CTRL_FINISH;
          we_n  <= 1'b1;
          oe_n  <= 1'b1;
        end
        CTRL_FINISH: begin
          // data stays on the bus one cycle past the rising we_n
          state      <= CTRL_IDLE;
          ce_n       <= 1'b1;
          drive_data <= 1'b0;
        end
        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  // request payload latched as the access starts
  always_ff @(posedge clk) begin
    if (state == CTRL_IDLE && bus.req) begin
      addr_bus  <= bus.addr;
      write_reg <= bus.write_data;
    end
  end

  // sample while oe_n is still low
  always_ff @(posedge clk) begin
    if (state == CTRL_STROBE && !write_cycle) begin
      bus.read_data <= data_bus;
    end
  end

  assign bus.ready = (state == CTRL_FINISH);
  assign data_bus  = drive_data ? write_reg : {DATA_BITS{1'bz}};

  ready_single_pulse: assert property (
    @(posedge clk) disable iff (reset)
    bus.ready |=> !bus.ready
  ) else $error("ready held high for two cycles");

  strobes_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(!we_n && !oe_n)
  ) else $error("we_n and oe_n low together");

endmodule

`default_nettype wire

// ==== verilog/sram_pattern_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_pattern_generator #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 next,
  input  wire logic [ADDR_BITS-1:0] addr,
  output logic      [DATA_BITS-1:0] pattern,
  output sram_test_pkg::pattern_kind_e kind,
  output logic                      last
);

  import sram_test_pkg::*;

  // 0101... repeated, low bit set
  logic [2*DATA_BITS-1:0]         alt_bits;
  // address widened so any DATA_BITS slice exists
  logic [DATA_BITS+ADDR_BITS-1:0] addr_ext;

  assign alt_bits = {DATA_BITS{2'b01}};
  assign addr_ext = {{DATA_BITS{1'b0}}, addr};

  // kind steps forward and stops on the final pattern
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      kind <= PAT_ZEROS;
    end else if (next && (int'(kind) < PATTERN_COUNT - 1)) begin
      kind <= pattern_kind_e'(kind + 3'd1);
    end
  end

  assign last = (kind == PAT_ADDR);

  always_comb begin
    case (kind)
      PAT_ZEROS: begin
        pattern = {DATA_BITS{1'b0}};
      end
      PAT_ONES: begin
        pattern = {DATA_BITS{1'b1}};
      end
      PAT_55: begin
        pattern = alt_bits[DATA_BITS-1:0];
      end
      PAT_AA: begin
        pattern = ~alt_bits[DATA_BITS-1:0];
      end
      PAT_ADDR: begin
        pattern = addr_ext[DATA_BITS-1:0];
      end
      default: begin
        pattern = {DATA_BITS{1'b0}};
      end
    endcase
  end

  no_next_past_last: assert property (
    @(posedge clk) disable iff (reset)
    next |-> !last
  ) else $error("pattern advance requested after the final pattern");

endmodule

`default_nettype wire

// ==== verilog/sram_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_tester #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  sram_req_if.tester                bus,
  input  wire logic [DATA_BITS-1:0] pattern,
  input  wire logic                 pattern_last,
  output logic                      pattern_next,
  output logic                      test_done,
  output logic                      test_pass,
  output logic      [DATA_BITS-1:0] prev_read_data,
  output logic      [DATA_BITS-1:0] prev_expected_data
);

  import sram_test_pkg::*;

  tester_state_e        state;
  tester_state_e        next_state;
  logic [ADDR_BITS-1:0] addr;
  // counter sits on the top address, next step wraps
  logic                 addr_last;
  logic                 read_pass;
  logic                 access_done;
  logic                 compare_valid;
  logic                 compare_fail;

  assign addr_last     = &addr;
  assign access_done   = bus.ready &&
                         (state == ST_WRITE_WAIT || state == ST_READ_WAIT);
  assign compare_fail  = compare_valid && (prev_read_data != prev_expected_data);

  always_comb begin
    next_state   = state;
    pattern_next = 1'b0;
    case (state)
      ST_START: begin
        // after reset, or one cycle after the last read of a pattern
        if (!read_pass) begin
          next_state = ST_WRITE;
        end else if (pattern_last) begin
          next_state = ST_DONE;
        end else begin
          pattern_next = 1'b1;
          next_state   = ST_WRITE;
        end
      end
      ST_WRITE: begin
        next_state = ST_WRITE_WAIT;
      end
      ST_WRITE_WAIT: begin
        if (bus.ready) begin
          next_state = addr_last ? ST_READ : ST_WRITE;
        end
      end
      ST_READ: begin
        next_state = ST_READ_WAIT;
      end
      ST_READ_WAIT: begin
        // last read goes through start so its compare lands first
        if (bus.ready) begin
          next_state = addr_last ? ST_START : ST_READ;
        end
      end
      ST_DONE, ST_HALT: begin
        next_state = state;
      end
      default: begin
        next_state = ST_START;
      end
    endcase
    if (compare_fail) begin
      next_state   = ST_HALT;
      pattern_next = 1'b0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_START;
      addr      <= {ADDR_BITS{1'b0}};
      read_pass <= 1'b0;
    end else begin
      state <= next_state;
      if (access_done) begin
        addr <= addr + 1'b1;
      end
      if (state == ST_WRITE_WAIT && bus.ready && addr_last) begin
        read_pass <= 1'b1;
      end else if (state == ST_START) begin
        read_pass <= 1'b0;
      end
    end
  end

  // held words, compared on the following edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      compare_valid      <= 1'b0;
      prev_read_data     <= {DATA_BITS{1'b0}};
      prev_expected_data <= {DATA_BITS{1'b0}};
    end else begin
      compare_valid <= 1'b0;
      if (state == ST_READ_WAIT && bus.ready) begin
        compare_valid      <= 1'b1;
        prev_read_data     <= bus.read_data;
        prev_expected_data <= pattern;
      end
    end
  end

  // result flags, sticky until reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_pass <= 1'b1;
      test_done <= 1'b0;
    end else begin
      if (compare_fail) begin
        test_pass <= 1'b0;
      end
      if (state == ST_DONE || state == ST_HALT) begin
        test_done <= 1'b1;
      end
    end
  end

  assign bus.req          = (state == ST_WRITE || state == ST_READ);
  assign bus.write_enable = (state == ST_WRITE);
  assign bus.addr         = addr;
  assign bus.write_data   = pattern;

  // controller only takes a request while idle
  no_overlapping_req: assert property (
    @(posedge clk) disable iff (reset)
    bus.req |=> (!bus.req until_with bus.ready)
  ) else $error("request issued while an access is outstanding");

endmodule

`default_nettype wire

// ==== verilog/sram_bist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bist_top #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire logic                    clk,
  input  wire logic                    reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_test_pkg::pattern_kind_e pattern_state,
  output logic         [DATA_BITS-1:0] prev_read_data,
  output logic         [DATA_BITS-1:0] prev_expected_data,
  output logic         [ADDR_BITS-1:0] addr_bus,
  inout  wire          [DATA_BITS-1:0] data_bus,
  output logic                         we_n,
  output logic                         oe_n,
  output logic                         ce_n
);

  logic [DATA_BITS-1:0] pattern;
  logic                 pattern_last;
  logic                 pattern_next;

  sram_req_if #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) req_bus ();

  sram_tester #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_tester (
    .clk               (clk),
    .reset             (reset),
    .bus               (req_bus.tester),
    .pattern           (pattern),
    .pattern_last      (pattern_last),
    .pattern_next      (pattern_next),
    .test_done         (test_done),
    .test_pass         (test_pass),
    .prev_read_data    (prev_read_data),
    .prev_expected_data(prev_expected_data)
  );

  sram_pattern_generator #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_pattern_gen (
    .clk    (clk),
    .reset  (reset),
    .next   (pattern_next),
    .addr   (req_bus.addr),
    .pattern(pattern),
    .kind   (pattern_state),
    .last   (pattern_last)
  );

  sram_controller #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_controller (
    .clk     (clk),
    .reset   (reset),
    .bus     (req_bus.controller),
    .addr_bus(addr_bus),
    .data_bus(data_bus),
    .we_n    (we_n),
    .oe_n    (oe_n),
    .ce_n    (ce_n)
  );

endmodule

`default_nettype wire

// ==== testbench/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire logic [ADDR_BITS-1:0]         addr,
  inout  wire       [DATA_BITS-1:0]         data,
  input  wire logic                         we_n,
  input  wire logic                         oe_n,
  input  wire logic                         ce_n,
  input  wire logic                         fault_enable,
  input  wire logic [ADDR_BITS-1:0]         fault_addr,
  input  wire logic [$clog2(DATA_BITS)-1:0] fault_bit,
  input  wire logic                         fault_value
);

  logic [DATA_BITS-1:0] mem [0:(1 << ADDR_BITS)-1];
  logic [DATA_BITS-1:0] stored_word;
  logic [DATA_BITS-1:0] fault_mask;
  logic [DATA_BITS-1:0] read_word;
  logic                 output_on;

  // cell contents are latched as we_n rises
  always @(posedge we_n) begin
    if (ce_n === 1'b0) begin
      mem[addr] <= data;
    end
  end

  assign stored_word = mem[addr];

  // one stuck cell bit, seen on every read of that address
  assign fault_mask = (fault_enable && (addr == fault_addr)) ?
                      ({{(DATA_BITS-1){1'b0}}, 1'b1} << fault_bit) :
                      {DATA_BITS{1'b0}};
  assign read_word  = fault_value ? (stored_word | fault_mask) :
                                    (stored_word & ~fault_mask);

  // outputs enabled only for a plain read
  assign output_on = (ce_n === 1'b0) && (oe_n === 1'b0) && (we_n === 1'b1);
  assign data      = output_on ? read_word : {DATA_BITS{1'bz}};

endmodule

`default_nettype wire

// ==== testbench/tb_sram_bist.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_bist;

  import sram_test_pkg::*;

  localparam int ADDR_BITS    = 6;
  localparam int DATA_BITS    = 8;
  localparam int BIT_SEL_BITS = $clog2(DATA_BITS);
  localparam int CASE_COUNT   = 6;
  // a clean run takes about 5 * 2 * 64 * 4 cycles
  localparam int DONE_TIMEOUT = 20000;
  localparam int HOLD_CYCLES  = 8;

  typedef struct packed {
    logic                    enable;
    logic [ADDR_BITS-1:0]    addr;
    logic [BIT_SEL_BITS-1:0] bit_sel;
    logic                    value;
  } fault_case_t;

  logic                    clk;
  logic                    reset;
  logic                    test_done;
  logic                    test_pass;
  pattern_kind_e           pattern_state;
  logic [DATA_BITS-1:0]    prev_read_data;
  logic [DATA_BITS-1:0]    prev_expected_data;
  logic [ADDR_BITS-1:0]    addr_bus;
  wire  [DATA_BITS-1:0]    data_bus;
  logic                    we_n;
  logic                    oe_n;
  logic                    ce_n;
  logic                    fault_enable;
  logic [ADDR_BITS-1:0]    fault_addr;
  logic [BIT_SEL_BITS-1:0] fault_bit;
  logic                    fault_value;

  fault_case_t cases [CASE_COUNT];
  integer      seed;
  integer      ce_low_cycles;

  sram_bist_top #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_dut (
    .clk               (clk),
    .reset             (reset),
    .test_done         (test_done),
    .test_pass         (test_pass),
    .pattern_state     (pattern_state),
    .prev_read_data    (prev_read_data),
    .prev_expected_data(prev_expected_data),
    .addr_bus          (addr_bus),
    .data_bus          (data_bus),
    .we_n              (we_n),
    .oe_n              (oe_n),
    .ce_n              (ce_n)
  );

  sram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_sram (
    .addr        (addr_bus),
    .data        (data_bus),
    .we_n        (we_n),
    .oe_n        (oe_n),
    .ce_n        (ce_n),
    .fault_enable(fault_enable),
    .fault_addr  (fault_addr),
    .fault_bit   (fault_bit),
    .fault_value (fault_value)
  );

  always #10 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] got,
                            input logic [DATA_BITS-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_kind(input string name, input pattern_kind_e got,
                            input pattern_kind_e exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // word written for a pattern kind at one address
  function automatic logic [DATA_BITS-1:0] kind_word(input pattern_kind_e kind,
                                                     input logic [ADDR_BITS-1:0] a);
    logic [DATA_BITS-1:0] word;
    case (kind)
      PAT_ZEROS: word = {DATA_BITS{1'b0}};
      PAT_ONES:  word = {DATA_BITS{1'b1}};
      PAT_55:    word = {(DATA_BITS/2){2'b01}};
      PAT_AA:    word = {(DATA_BITS/2){2'b10}};
      default:   word = DATA_BITS'(a);
    endcase
    return word;
  endfunction

  // first pattern whose word disagrees with the stuck bit fails
  task automatic predict_result(input fault_case_t fc, output logic pass,
                                output pattern_kind_e kind,
                                output logic [DATA_BITS-1:0] exp_word,
                                output logic [DATA_BITS-1:0] read_word);
    logic [DATA_BITS-1:0] word;
    logic                 found;
    found     = 1'b0;
    pass      = 1'b1;
    kind      = PAT_ADDR;
    exp_word  = kind_word(PAT_ADDR, {ADDR_BITS{1'b1}});
    read_word = exp_word;
    for (int k = 0; k < PATTERN_COUNT; k++) begin
      word = kind_word(pattern_kind_e'(k), fc.addr);
      if (fc.enable && !found && (word[fc.bit_sel] != fc.value)) begin
        found              = 1'b1;
        pass               = 1'b0;
        kind               = pattern_kind_e'(k);
        exp_word           = word;
        read_word          = word;
        read_word[fc.bit_sel] = fc.value;
      end
    end
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (!test_done && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!test_done) begin
      report_failure("test_done never rose before the timeout");
    end
  endtask

  task automatic run_case(input int index, input fault_case_t fc);
    logic                 exp_pass;
    pattern_kind_e        exp_kind;
    logic [DATA_BITS-1:0] exp_word;
    logic [DATA_BITS-1:0] exp_read;
    $display("case %0d: fault %0b addr %0d bit %0d stuck %0b",
             index, fc.enable, fc.addr, fc.bit_sel, fc.value);
    @(negedge clk);
    reset        = 1'b1;
    fault_enable = fc.enable;
    fault_addr   = fc.addr;
    fault_bit    = fc.bit_sel;
    fault_value  = fc.value;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_flag("test_done", test_done, 1'b0);
    check_flag("test_pass", test_pass, 1'b1);
    wait_for_done();
    predict_result(fc, exp_pass, exp_kind, exp_word, exp_read);
    check_flag("test_pass", test_pass, exp_pass);
    check_kind("pattern_state", pattern_state, exp_kind);
    check_word("prev_expected_data", prev_expected_data, exp_word);
    check_word("prev_read_data", prev_read_data, exp_read);
    // results stay frozen and the pins go quiet
    repeat (HOLD_CYCLES) @(negedge clk);
    check_flag("test_done", test_done, 1'b1);
    check_flag("test_pass", test_pass, exp_pass);
    check_word("prev_read_data", prev_read_data, exp_read);
    check_flag("ce_n", ce_n, 1'b1);
  endtask

  // pin protocol watched across every run
  always @(negedge clk) begin
    if (reset) begin
      ce_low_cycles = 0;
    end else begin
      if (!we_n && !oe_n) begin
        report_failure("we_n and oe_n were low at the same time");
      end
      if (ce_n && (!we_n || !oe_n)) begin
        report_failure("a strobe went low while ce_n was high");
      end
      if (ce_n) begin
        ce_low_cycles = 0;
      end else begin
        ce_low_cycles = ce_low_cycles + 1;
      end
      if (ce_low_cycles > 3) begin
        report_failure("ce_n stayed low longer than one access");
      end
    end
  end

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    fault_enable  = 1'b0;
    fault_addr    = '0;
    fault_bit     = '0;
    fault_value   = 1'b0;
    ce_low_cycles = 0;
    seed          = 32'h6ab60f8c;

    // enable, address, bit, stuck value
    cases[0] = '{1'b0, 6'd0,  3'd0, 1'b0};
    cases[1] = '{1'b1, 6'd10, 3'd3, 1'b1};
    cases[2] = '{1'b1, 6'd37, 3'd5, 1'b0};
    cases[3] = '{1'b1, 6'd0,  3'd0, 1'b1};
    cases[4] = '{1'b1, 6'd63, 3'd7, 1'b0};
    cases[5].enable  = 1'b1;
    cases[5].addr    = ADDR_BITS'($random(seed));
    cases[5].bit_sel = BIT_SEL_BITS'($random(seed));
    cases[5].value   = 1'($random(seed));

    for (int i = 0; i < CASE_COUNT; i++) begin
      run_case(i, cases[i]);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/sram_test_pkg.sv
verilog/sram_req_if.sv
verilog/sram_controller.sv
verilog/sram_pattern_generator.sv
verilog/sram_tester.sv
verilog/sram_bist_top.sv
testbench/sram_model.sv
testbench/tb_sram_bist.sv
